// File: sources.f
hw/hssi_emul_pkg.sv
hw/hssi_stream_if.sv
hw/hssi_credit_fifo.sv
hw/hssi_frame_decode.sv
hw/hssi_pause_exec.sv
hw/hssi_rx_result.sv
hw/hssi_chan_emul.sv
verification/tb_hssi_chan_emul.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the HSSI channel emulator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_hssi_chan_emul -f sources.f

# The log decides pass or fail
./obj_dir/Vtb_hssi_chan_emul > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log
then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: verification/tb_hssi_chan_emul.sv
// ==============================
// Testbench for the HSSI channel emulator
// Clock, reset, TX source and RX sink models
// Scoreboard of data frame words
// Concurrent assertions for all checks
// ==============================

`timescale 1ns/1ps

module tb_hssi_chan_emul
    import hssi_emul_pkg::*;
();

    localparam int TX_CREDITS   = 4;
    localparam int LINK_CREDITS = 4;
    localparam int RX_CREDITS   = 4;
    localparam int CNT_W        = 16;
    localparam int NUM_FRAMES   = 33;
    // Frame index at which the sink withholds credits
    localparam int HOLD_FRAME   = 12;
    localparam int HOLD_CYCLES  = 40;

    logic             i_hssi_clk_pll;
    logic             i_rst_n;
    logic             i_tx_valid;
    t_eth_word        i_tx_data;
    logic             i_tx_last;
    logic             o_tx_credit;
    logic             o_rx_valid;
    t_eth_word        o_rx_data;
    logic             o_rx_last;
    logic             i_rx_credit;
    logic             o_rx_pause;
    logic [CNT_W-1:0] o_frame_cnt;
    logic [CNT_W-1:0] o_pause_cnt;

    int        seed;
    // Credit return gaps, drawn up front from the one seed
    int        gap_tab [256];
    int        tx_cred;
    int        sink_held;
    int        frame_idx;
    int        data_sent;
    int        pauses_sent;
    logic      drained;
    // Scoreboard, words of data frames in send order
    t_eth_word exp_word_q [$];
    logic      exp_last_q [$];
    int        rd_idx;
    logic      exp_avail;
    t_eth_word exp_word;
    logic      exp_last;

    hssi_chan_emul #(
        .TX_CREDITS   (TX_CREDITS),
        .LINK_CREDITS (LINK_CREDITS),
        .RX_CREDITS   (RX_CREDITS),
        .CNT_W        (CNT_W)
    ) hssi_chan_emul_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_tx_valid     (i_tx_valid),
        .i_tx_data      (i_tx_data),
        .i_tx_last      (i_tx_last),
        .o_tx_credit    (o_tx_credit),
        .o_rx_valid     (o_rx_valid),
        .o_rx_data      (o_rx_data),
        .o_rx_last      (o_rx_last),
        .i_rx_credit    (i_rx_credit),
        .o_rx_pause     (o_rx_pause),
        .o_frame_cnt    (o_frame_cnt),
        .o_pause_cnt    (o_pause_cnt)
    );

    // 10 ns clock
    initial
    begin
        i_hssi_clk_pll = 1'b0;
        forever #5 i_hssi_clk_pll = ~i_hssi_clk_pll;
    end

    // ==============================
    // Error reporting
    // ==============================

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    // ==============================
    // Source and sink credit models
    // ==============================

    // Credits held by the source, spent per beat, refilled per pulse
    always @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin
        if (!i_rst_n)
            tx_cred <= TX_CREDITS;
        else
            tx_cred <= tx_cred - int'(i_tx_valid) + int'(o_tx_credit);
    end

    // Beats sitting in the sink buffer, not yet freed
    always @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin
        if (!i_rst_n)
            sink_held <= 0;
        else
            sink_held <= sink_held + int'(o_rx_valid) - int'(i_rx_credit);
    end

    // Sink frees beats after random gaps, with one long hold
    initial
    begin : sink_model
        int   hold_left;
        logic hold_done;
        int   gap_left;
        int   gap_idx;
        hold_left   = 0;
        hold_done   = 1'b0;
        gap_left    = 0;
        gap_idx     = 0;
        i_rx_credit = 1'b0;
        forever
        begin
            @(negedge i_hssi_clk_pll);
            i_rx_credit = 1'b0;
            if (frame_idx == HOLD_FRAME && !hold_done)
            begin
                hold_left = HOLD_CYCLES;
                hold_done = 1'b1;
            end
            if (hold_left > 0)
                hold_left--;
            else if (sink_held > 0)
            begin
                if (gap_left == 0)
                begin
                    i_rx_credit = 1'b1;
                    gap_left    = gap_tab[gap_idx % 256];
                    gap_idx++;
                end
                else
                    gap_left--;
            end
        end
    end

    // Scoreboard head follows each RX beat
    always @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin : sb_follow
        int nxt;
        if (!i_rst_n)
        begin
            rd_idx    <= 0;
            exp_avail <= 1'b0;
        end
        else
        begin
            nxt    = rd_idx + int'(o_rx_valid);
            rd_idx <= nxt;
            if (nxt < exp_word_q.size())
            begin
                exp_avail <= 1'b1;
                exp_word  <= exp_word_q[nxt];
                exp_last  <= exp_last_q[nxt];
            end
            else
                exp_avail <= 1'b0;
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Outputs idle from the second reset cycle to the first cycle after release
    a_reset_state: assert property (@(posedge i_hssi_clk_pll)
        ((!i_rst_n && $past(!i_rst_n)) || $rose(i_rst_n)) |->
        (!o_rx_valid && !o_tx_credit && !o_rx_pause &&
         o_frame_cnt == '0 && o_pause_cnt == '0))
        else report_failure("DUT outputs not at reset values");

    a_rx_expected: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        o_rx_valid |-> exp_avail)
        else report_failure("RX beat with no data frame word outstanding");

    a_rx_data: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        (o_rx_valid && exp_avail) |-> (o_rx_data == exp_word))
        else report_mismatch("o_rx_data", $sampled(exp_word), $sampled(o_rx_data));

    a_rx_last: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        (o_rx_valid && exp_avail) |-> (o_rx_last == exp_last))
        else report_mismatch("o_rx_last", 64'($sampled(exp_last)),
                             64'($sampled(o_rx_last)));

    // Outstanding TX credits never negative, never more than the buffer
    a_tx_credit_range: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        (tx_cred >= 0) && (tx_cred <= TX_CREDITS))
        else report_failure("TX credit count left the range 0 to TX_CREDITS");

    a_tx_credit_home: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        drained |-> (tx_cred == TX_CREDITS))
        else report_mismatch("tx_cred", 64'(TX_CREDITS), 64'($sampled(tx_cred)));

    // Every RX beat needs a free slot in the sink
    a_rx_credit: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        o_rx_valid |-> (sink_held < RX_CREDITS))
        else report_failure("RX beat sent with no unspent credit");

    a_pause_blocks_rx: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        o_rx_pause |-> !o_rx_valid)
        else report_failure("RX beat delivered while paused");

    a_pause_cnt_rise: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        $rose(o_rx_pause) |-> (o_pause_cnt == CNT_W'(pauses_sent)))
        else report_mismatch("o_pause_cnt", 64'(CNT_W'(pauses_sent)),
                             64'($sampled(o_pause_cnt)));

    a_pause_cnt_fall: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        $fell(o_rx_pause) |-> (o_pause_cnt == CNT_W'(pauses_sent)))
        else report_mismatch("o_pause_cnt", 64'(CNT_W'(pauses_sent)),
                             64'($sampled(o_pause_cnt)));

    a_frame_cnt: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        drained |-> (o_frame_cnt == CNT_W'(data_sent)))
        else report_mismatch("o_frame_cnt", 64'(CNT_W'(data_sent)),
                             64'($sampled(o_frame_cnt)));

    // ==============================
    // Stimulus tasks
    // ==============================

    // One beat, only with a TX credit in hand
    task automatic send_beat(input t_eth_word w, input logic last);
        int waited;
        waited = 0;
        while (tx_cred == 0)
        begin
            @(negedge i_hssi_clk_pll);
            waited++;
            if (waited > 200)
                report_failure("timeout waiting for a TX credit");
        end
        i_tx_valid = 1'b1;
        i_tx_data  = w;
        i_tx_last  = last;
        @(negedge i_hssi_clk_pll);
        i_tx_valid = 1'b0;
        i_tx_last  = 1'b0;
    endtask

    task automatic send_data_frame();
        int        len;
        int        b;
        t_eth_word w;
        len = ($random(seed) & 3) + 1;
        for (b = 0; b < len; b++)
        begin
            w = {$random(seed), $random(seed)};
            // Keep data frames clear of the pause ethertype
            if (b == 0 && w[15:0] == PAUSE_ETYPE)
                w[0] = ~w[0];
            exp_word_q.push_back(w);
            exp_last_q.push_back(b == len - 1);
            send_beat(w, b == len - 1);
        end
        data_sent++;
    endtask

    task automatic wait_pause_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (o_rx_pause !== level)
        begin
            @(negedge i_hssi_clk_pll);
            n++;
            if (n > limit)
                report_failure({"timeout waiting for ", what});
        end
    endtask

    // All data words delivered and all sink slots freed
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (rd_idx != exp_word_q.size() || sink_held != 0)
        begin
            @(negedge i_hssi_clk_pll);
            n++;
            if (n > limit)
                report_failure("timeout waiting for the RX drain");
        end
    endtask

    // Ethertype in word 0, quanta in word 1, 2 to 4 beats
    // A data frame is queued behind it while the pause runs
    task automatic send_pause_frame();
        int        len;
        int        b;
        int        quanta;
        t_eth_word w;
        len    = 2 + (($random(seed) & 7) % 3);
        quanta = 5 + ($random(seed) & 15);
        for (b = 0; b < len; b++)
        begin
            w = {$random(seed), $random(seed)};
            if (b == 0)
                w[15:0] = PAUSE_ETYPE;
            else if (b == 1)
                w[15:0] = 16'(quanta);
            send_beat(w, b == len - 1);
        end
        pauses_sent++;
        wait_pause_level(1'b1, 40, "o_rx_pause to rise");
        send_data_frame();
        wait_pause_level(1'b0, quanta + 40, "o_rx_pause to fall");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin : stimulus
        int f;
        int idle;
        seed = 98;
        for (f = 0; f < 256; f++)
            gap_tab[f] = $random(seed) & 3;
        i_rst_n     = 1'b0;
        i_tx_valid  = 1'b0;
        i_tx_data   = '0;
        i_tx_last   = 1'b0;
        frame_idx   = 0;
        data_sent   = 0;
        pauses_sent = 0;
        drained     = 1'b0;
        repeat (5) @(negedge i_hssi_clk_pll);
        i_rst_n = 1'b1;
        repeat (2) @(negedge i_hssi_clk_pll);
        for (f = 0; f < NUM_FRAMES; f++)
        begin
            frame_idx = f;
            // Pipeline empty before a pause so held traffic is all behind it
            if (f == 6 || f == 17 || f == 27)
            begin
                wait_drained(500);
                send_pause_frame();
            end
            else
                send_data_frame();
            idle = $random(seed) & 3;
            repeat (idle) @(negedge i_hssi_clk_pll);
        end
        wait_drained(500);
        drained = 1'b1;
        repeat (2) @(negedge i_hssi_clk_pll);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: hw/hssi_chan_emul.sv
// ==============================
// HSSI channel emulator top level
// TX to RX loopback of data frames
// Pause frames drive the RX pause flag
// decode, execute and result stages
// ==============================

`timescale 1ns/1ps

module hssi_chan_emul
    import hssi_emul_pkg::*;
#(
    parameter int TX_CREDITS   = 4,
    parameter int LINK_CREDITS = 4,
    parameter int RX_CREDITS   = 4,
    parameter int CNT_W        = 16
) (
    input  logic             i_hssi_clk_pll,
    input  logic             i_rst_n,
    // TX stream from the accelerator
    input  logic             i_tx_valid,
    input  t_eth_word        i_tx_data,
    input  logic             i_tx_last,
    output logic             o_tx_credit,
    // RX stream toward the accelerator
    output logic             o_rx_valid,
    output t_eth_word        o_rx_data,
    output logic             o_rx_last,
    input  logic             i_rx_credit,
    // Status
    output logic             o_rx_pause,
    output logic [CNT_W-1:0] o_frame_cnt,
    output logic [CNT_W-1:0] o_pause_cnt
);

    // ==============================
    // Internal links
    // ==============================

    // Tagged beats, decode to execute
    hssi_stream_if #(.T(t_dec_word)) dec_link ();
    // Plain data beats, execute to result
    hssi_stream_if #(.T(t_eth_word)) res_link ();

    // ==============================
    // Stages
    // ==============================

    hssi_frame_decode #(
        .TX_CREDITS   (TX_CREDITS),
        .LINK_CREDITS (LINK_CREDITS)
    ) decode_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_tx_valid     (i_tx_valid),
        .i_tx_data      (i_tx_data),
        .i_tx_last      (i_tx_last),
        .o_tx_credit    (o_tx_credit),
        .o_link         (dec_link)
    );

    // Pause handling sits between classification and delivery
    hssi_pause_exec #(
        .LINK_CREDITS (LINK_CREDITS),
        .CNT_W        (CNT_W)
    ) exec_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_link         (dec_link),
        .o_link         (res_link),
        .o_rx_pause     (o_rx_pause),
        .o_pause_cnt    (o_pause_cnt)
    );

    hssi_rx_result #(
        .LINK_CREDITS (LINK_CREDITS),
        .RX_CREDITS   (RX_CREDITS),
        .CNT_W        (CNT_W)
    ) result_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_link         (res_link),
        .i_rx_credit    (i_rx_credit),
        .o_rx_valid     (o_rx_valid),
        .o_rx_data      (o_rx_data),
        .o_rx_last      (o_rx_last),
        .o_frame_cnt    (o_frame_cnt)
    );

endmodule

// File: hw/hssi_rx_result.sv
// ==============================
// Result stage
// Spends RX credits to drive the RX stream
// Counts delivered data frames
// ==============================

`timescale 1ns/1ps

module hssi_rx_result
    import hssi_emul_pkg::*;
#(
    parameter int LINK_CREDITS = 4,
    parameter int RX_CREDITS   = 4,
    parameter int CNT_W        = 16
) (
    input  logic             i_hssi_clk_pll,
    input  logic             i_rst_n,
    hssi_stream_if.snk       i_link,
    input  logic             i_rx_credit,
    output logic             o_rx_valid,
    output t_eth_word        o_rx_data,
    output logic             o_rx_last,
    output logic [CNT_W-1:0] o_frame_cnt
);

    localparam int RC_W = $clog2(RX_CREDITS + 1);

    logic            buf_valid;
    t_eth_word       buf_word;
    logic            buf_last;
    logic            pop;
    // Credits not yet spent by a beat on the RX bus
    logic [RC_W-1:0] rx_cnt;
    logic [RC_W-1:0] rx_avail;

    hssi_credit_fifo #(
        .T     (t_eth_word),
        .DEPTH (LINK_CREDITS)
    ) rx_buf_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_push         (i_link.valid),
        .i_payload      (i_link.payload),
        .i_last         (i_link.last),
        .i_pop          (pop),
        .o_valid        (buf_valid),
        .o_payload      (buf_word),
        .o_last         (buf_last),
        .o_credit       (i_link.credit)
    );

    // Beat in the output register already claims one credit
    assign rx_avail = rx_cnt - RC_W'(o_rx_valid);
    assign pop      = buf_valid && (rx_avail != '0);

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (pop)
        begin
            o_rx_data <= buf_word;
            o_rx_last <= buf_last;
        end
    end

    always_ff @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_rx_valid  <= 1'b0;
            rx_cnt      <= RC_W'(RX_CREDITS);
            o_frame_cnt <= '0;
        end
        else
        begin
            o_rx_valid <= pop;
            // Credit is spent when the beat leaves, refilled by the sink
            rx_cnt     <= rx_cnt - RC_W'(o_rx_valid) + RC_W'(i_rx_credit);
            if (o_rx_valid && o_rx_last)
                o_frame_cnt <= o_frame_cnt + 1'b1;
        end
    end

    // Sink buffer space must back every beat on the RX bus
    a_rx_credit: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        o_rx_valid |-> (rx_cnt != '0))
        else $error("hssi_rx_result: RX beat sent without credit");

endmodule

// File: hw/hssi_pause_exec.sv
// ==============================
// Execute stage
// Consumes pause frames, runs the pause timer
// Forwards data beats when not paused
// ==============================

`timescale 1ns/1ps

module hssi_pause_exec
    import hssi_emul_pkg::*;
#(
    parameter int LINK_CREDITS = 4,
    parameter int CNT_W        = 16
) (
    input  logic             i_hssi_clk_pll,
    input  logic             i_rst_n,
    hssi_stream_if.snk       i_link,
    hssi_stream_if.src       o_link,
    output logic             o_rx_pause,
    output logic [CNT_W-1:0] o_pause_cnt
);

    localparam int LC_W = $clog2(LINK_CREDITS + 1);

    logic                buf_valid;
    t_dec_word           buf_beat;
    logic                buf_last;
    logic                pop_pause;
    logic                pop_data;
    logic [LC_W-1:0]     link_cnt;
    // Beat position inside a pause frame, saturates at 2
    logic [1:0]          p_idx;
    logic [QUANTA_W-1:0] quanta_r;
    logic [QUANTA_W-1:0] quanta_next;
    logic [QUANTA_W-1:0] pause_timer;
    logic                pause_load;

    hssi_credit_fifo #(
        .T     (t_dec_word),
        .DEPTH (LINK_CREDITS)
    ) link_buf_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_push         (i_link.valid),
        .i_payload      (i_link.payload),
        .i_last         (i_link.last),
        .i_pop          (pop_pause || pop_data),
        .o_valid        (buf_valid),
        .o_payload      (buf_beat),
        .o_last         (buf_last),
        .o_credit       (i_link.credit)
    );

    // Pause beats drain freely, data waits for timer and credit
    assign pop_pause  = buf_valid && (buf_beat.kind == FK_PAUSE);
    assign pop_data   = buf_valid && (buf_beat.kind == FK_DATA) &&
                        (pause_timer == '0) && (link_cnt != '0);
    assign pause_load = pop_pause && buf_last;
    assign o_rx_pause = (pause_timer != '0);

    // Quanta sit in the second word, a one-beat pause frame carries none
    always_comb
    begin
        case (p_idx)
            2'd0:    quanta_next = '0;
            2'd1:    quanta_next = buf_beat.word[QUANTA_W-1:0];
            default: quanta_next = quanta_r;
        endcase
    end

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (pop_pause && (p_idx == 2'd1))
            quanta_r <= buf_beat.word[QUANTA_W-1:0];
        if (pop_data)
        begin
            o_link.payload <= buf_beat.word;
            o_link.last    <= buf_last;
        end
    end

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            p_idx        <= '0;
            pause_timer  <= '0;
            o_pause_cnt  <= '0;
            link_cnt     <= LC_W'(LINK_CREDITS);
            o_link.valid <= 1'b0;
        end
        else
        begin
            o_link.valid <= pop_data;
            if (pause_load)
                p_idx <= '0;
            else if (pop_pause && (p_idx != 2'd2))
                p_idx <= p_idx + 1'b1;
            // Load after the last pause beat, then count down per cycle
            if (pause_load)
            begin
                pause_timer <= quanta_next;
                o_pause_cnt <= o_pause_cnt + 1'b1;
            end
            else if (pause_timer != '0)
                pause_timer <= pause_timer - 1'b1;
            case ({pop_data, o_link.credit})
                2'b10:   link_cnt <= link_cnt - 1'b1;
                2'b01:   link_cnt <= link_cnt + 1'b1;
                default: link_cnt <= link_cnt;
            endcase
        end
    end

    // No forwarded beat on the output link while the pause flag is up
    a_no_data_paused: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        o_link.valid |-> !o_rx_pause)
        else $error("hssi_pause_exec: data beat forwarded while paused");

endmodule

// File: hw/hssi_frame_decode.sv
// ==============================
// Decode stage
// Buffers TX beats from the accelerator
// Tracks frame starts, tags beats with frame kind
// Spends link credits toward execute
// ==============================

`timescale 1ns/1ps

module hssi_frame_decode
    import hssi_emul_pkg::*;
#(
    parameter int TX_CREDITS   = 4,
    parameter int LINK_CREDITS = 4
) (
    input  logic          i_hssi_clk_pll,
    input  logic          i_rst_n,
    input  logic          i_tx_valid,
    input  t_eth_word     i_tx_data,
    input  logic          i_tx_last,
    output logic          o_tx_credit,
    hssi_stream_if.src    o_link
);

    localparam int LC_W = $clog2(LINK_CREDITS + 1);

    logic            buf_valid;
    t_eth_word       buf_word;
    logic            buf_last;
    logic            pop;
    logic [LC_W-1:0] link_cnt;
    // High when the next beat opens a new frame
    logic            sof;
    t_frame_kind     cur_kind;
    t_frame_kind     beat_kind;

    // TX buffer, its credits go straight back to the accelerator
    hssi_credit_fifo #(
        .T     (t_eth_word),
        .DEPTH (TX_CREDITS)
    ) tx_buf_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst_n        (i_rst_n),
        .i_push         (i_tx_valid),
        .i_payload      (i_tx_data),
        .i_last         (i_tx_last),
        .i_pop          (pop),
        .o_valid        (buf_valid),
        .o_payload      (buf_word),
        .o_last         (buf_last),
        .o_credit       (o_tx_credit)
    );

    // Move a beat only with a link credit in hand
    assign pop = buf_valid && (link_cnt != '0);

    // First word decides the kind, later words inherit it
    always_comb
    begin
        if (!sof)
            beat_kind = cur_kind;
        else if (buf_word[15:0] == PAUSE_ETYPE)
            beat_kind = FK_PAUSE;
        else
            beat_kind = FK_DATA;
    end

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            sof          <= 1'b1;
            cur_kind     <= FK_DATA;
            link_cnt     <= LC_W'(LINK_CREDITS);
            o_link.valid <= 1'b0;
        end
        else
        begin
            o_link.valid <= pop;
            if (pop)
            begin
                sof      <= buf_last;
                cur_kind <= beat_kind;
            end
            // Spend on pop, refill on returned credit
            case ({pop, o_link.credit})
                2'b10:   link_cnt <= link_cnt - 1'b1;
                2'b01:   link_cnt <= link_cnt + 1'b1;
                default: link_cnt <= link_cnt;
            endcase
        end
    end

    // Output beat register
    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (pop)
        begin
            o_link.payload <= '{word: buf_word, kind: beat_kind};
            o_link.last    <= buf_last;
        end
    end

    // Execute never returns more credits than it was given
    a_link_cnt_max: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        link_cnt <= LC_W'(LINK_CREDITS))
        else $error("hssi_frame_decode: link credit count above LINK_CREDITS");

endmodule

// File: hw/hssi_credit_fifo.sv
// ==============================
// Circular beat buffer with credit return
// Payload type is a parameter
// One credit pulse per popped beat
// ==============================

`timescale 1ns/1ps

module hssi_credit_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 4
) (
    input  logic i_hssi_clk_pll,
    input  logic i_rst_n,
    input  logic i_push,
    input  T     i_payload,
    input  logic i_last,
    input  logic i_pop,
    output logic o_valid,
    output T     o_payload,
    output logic o_last,
    output logic o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int OCC_W = $clog2(DEPTH + 1);

    // Storage, no reset needed
    T                 mem_payload [DEPTH];
    logic             mem_last [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] occ;
    logic             do_pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // Head of buffer is always presented
    assign o_valid   = (occ != '0);
    assign o_payload = mem_payload[rd_ptr];
    assign o_last    = mem_last[rd_ptr];
    assign do_pop    = i_pop && o_valid;

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (i_push)
        begin
            mem_payload[wr_ptr] <= i_payload;
            mem_last[wr_ptr]    <= i_last;
        end
    end

    // Pointers, occupancy and credit pulse
    always_ff @(posedge i_hssi_clk_pll or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            occ      <= '0;
            o_credit <= 1'b0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({i_push, do_pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
            // Slot freed by a pop is returned one cycle later
            o_credit <= do_pop;
        end
    end

    // Sender must hold a credit, so it can never push into a full buffer
    a_no_overflow: assert property (@(posedge i_hssi_clk_pll) disable iff (!i_rst_n)
        i_push |-> (occ != OCC_W'(DEPTH)))
        else $error("hssi_credit_fifo: push while full, credit violation");

endmodule

// File: hw/hssi_stream_if.sv
// ==============================
// Credit-controlled beat stream between emulator stages
// Payload type is a parameter
// src and snk modports
// ==============================

`timescale 1ns/1ps

interface hssi_stream_if #(
    parameter type T = logic
) ();

    // Beat qualifier, one beat per cycle at most
    logic valid;
    // Beat contents
    T     payload;
    // Marks the final beat of a frame
    logic last;
    // One pulse per buffer slot freed at the receiver
    logic credit;

    // Sending side, spends credits
    modport src (
        output valid,
        output payload,
        output last,
        input  credit
    );

    // Receiving side, returns credits
    modport snk (
        input  valid,
        input  payload,
        input  last,
        output credit
    );

endinterface

// File: hw/hssi_emul_pkg.sv
// ==============================
// Shared definitions for the HSSI channel emulator
// Stream word type and width
// Frame kind enumeration
// Decoded word struct (word plus kind)
// Pause frame constants
// ==============================

package hssi_emul_pkg;

    // ==============================
    // Stream word
    // ==============================

    // Width of one beat on every stream
    localparam int DATA_W = 64;

    // One raw Ethernet word as carried on TX and RX
    typedef logic [DATA_W-1:0] t_eth_word;

    // ==============================
    // Frame classification
    // ==============================

    // Kind of the frame a beat belongs to
    typedef enum logic {
        FK_DATA  = 1'b0,
        FK_PAUSE = 1'b1
    } t_frame_kind;

    // Word tagged with its frame kind, carried from decode to execute
    typedef struct packed {
        t_eth_word   word;
        t_frame_kind kind;
    } t_dec_word;

    // ==============================
    // Pause frame fields
    // ==============================

    // Ethertype in bits 15..0 of the first word of a pause frame
    localparam logic [15:0] PAUSE_ETYPE = 16'h8808;

    // Quanta field, bits 15..0 of the second word
    localparam int QUANTA_W = 16;

endpackage
